//--- Makefile
# Verilator build and run of the crossbar testbench

LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f files.f --top-module tb_top -o Vtb_top

run: build
	./obj_dir/Vtb_top | tee $(LOG)
	grep -q "All tests passed" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f files.f --top-module xbar_top

clean:
	rm -rf obj_dir $(LOG)

//--- files.f
+incdir+include
logic/xbar_pkg.sv
logic/xbar_addr_decode.sv
logic/xbar_rr_arbiter.sv
logic/xbar_write_path.sv
logic/xbar_read_path.sv
logic/xbar_top.sv
verif/xbar_checker.sv
verif/tb_top.sv

//--- include/xbar_settings.svh
// build-time settings for the crossbar
// the address map is fixed, regions must not overlap
// every region needs the upper 32 address bits at zero
// a mask is region size minus one, so sizes are powers of two
`ifndef XBAR_SETTINGS_SVH
`define XBAR_SETTINGS_SVH

`define XBAR_MGR_N 3   // dm, ifu, lsu
`define XBAR_SUB_N 5   // clint, plic, preph, sys, mem

`define XBAR_ADDR_W 64
`define XBAR_DATA_W 64

// 64 KiB
`define XBAR_CLINT_BASE 64'h0000_0000_0200_0000
`define XBAR_CLINT_MASK 64'h0000_0000_0000_ffff
// 64 MiB
`define XBAR_PLIC_BASE  64'h0000_0000_0c00_0000
`define XBAR_PLIC_MASK  64'h0000_0000_03ff_ffff
// 256 MiB
`define XBAR_PREPH_BASE 64'h0000_0000_2000_0000
`define XBAR_PREPH_MASK 64'h0000_0000_0fff_ffff
// 1 GiB
`define XBAR_SYS_BASE   64'h0000_0000_4000_0000
`define XBAR_SYS_MASK   64'h0000_0000_3fff_ffff
// 2 GiB
`define XBAR_MEM_BASE   64'h0000_0000_8000_0000
`define XBAR_MEM_MASK   64'h0000_0000_7fff_ffff

`endif

//--- logic/xbar_addr_decode.sv
// address to subordinate index, purely combinational
// index order clint, plic, preph, sys, mem
// miss is high when no region matches, sub_sel is then 0
`include "xbar_settings.svh"

module xbar_addr_decode
	import xbar_pkg::*;
(
	input addr_t addr,
	output sub_idx_t sub_sel,
	output logic miss
);

	localparam addr_t REGION_BASE [`XBAR_SUB_N] = '{
		`XBAR_CLINT_BASE,
		`XBAR_PLIC_BASE,
		`XBAR_PREPH_BASE,
		`XBAR_SYS_BASE,
		`XBAR_MEM_BASE
	};
	localparam addr_t REGION_MASK [`XBAR_SUB_N] = '{
		`XBAR_CLINT_MASK,
		`XBAR_PLIC_MASK,
		`XBAR_PREPH_MASK,
		`XBAR_SYS_MASK,
		`XBAR_MEM_MASK
	};

	sub_vec_t hit;

	always_comb begin
		sub_sel = '0;
		for (int s = 0; s < `XBAR_SUB_N; s++) begin
			hit[s] = (addr & ~REGION_MASK[s]) == REGION_BASE[s];   // upper bits must be zero too
			if (hit[s]) begin
				sub_sel = sub_idx_t'(s);
			end
		end
		miss = ~|hit;
		// overlapping regions would make the routing ambiguous
		assert ($onehot0(hit));
	end

endmodule

//--- logic/xbar_pkg.sv
// types shared by the crossbar and its testbench
// widths come from the settings header
// wr_req_t carries AW and W together, no prot, id or burst fields
`include "xbar_settings.svh"

package xbar_pkg;

	typedef logic [`XBAR_ADDR_W-1:0] addr_t;
	typedef logic [`XBAR_DATA_W-1:0] data_t;
	typedef logic [`XBAR_DATA_W/8-1:0] strb_t;
	typedef logic [1:0] resp_t;

	typedef logic [$clog2(`XBAR_MGR_N)-1:0] mgr_idx_t;
	typedef logic [$clog2(`XBAR_SUB_N)-1:0] sub_idx_t;
	typedef logic [`XBAR_MGR_N-1:0] mgr_vec_t;   // bit 0 is dm
	typedef logic [`XBAR_SUB_N-1:0] sub_vec_t;   // bit 0 is clint

	// AXI response codes, only these two are produced here
	localparam resp_t RESP_OKAY = 2'b00;
	localparam resp_t RESP_DECERR = 2'b11;

	// AW + W in one beat
	typedef struct packed {
		addr_t addr;
		data_t data;
		strb_t strb;
	} wr_req_t;

	typedef struct packed {
		resp_t resp;
	} wr_rsp_t;

	typedef struct packed {
		addr_t addr;
	} rd_req_t;

	typedef struct packed {
		data_t data;
		resp_t resp;
	} rd_rsp_t;

endpackage

//--- logic/xbar_read_path.sv
// read side of the crossbar, mirrors the write side
// one read in flight per manager, lane locked until R is taken
// unmapped reads get DECERR with zero data a cycle later
`include "xbar_settings.svh"

module xbar_read_path
	import xbar_pkg::*;
(
	input logic clk,
	input logic arst_n,
	// manager side
	input rd_req_t [`XBAR_MGR_N-1:0] rd_req,
	input mgr_vec_t rd_valid,
	output mgr_vec_t rd_ready,
	output rd_rsp_t [`XBAR_MGR_N-1:0] rd_rsp,
	output mgr_vec_t r_valid,
	input mgr_vec_t r_ready,
	// subordinate side
	output rd_req_t [`XBAR_SUB_N-1:0] s_rd_req,
	output sub_vec_t s_rd_valid,
	input sub_vec_t s_rd_ready,
	input rd_rsp_t [`XBAR_SUB_N-1:0] s_rd_rsp,
	input sub_vec_t s_r_valid,
	output sub_vec_t s_r_ready
);

	sub_idx_t sel [`XBAR_MGR_N];
	mgr_vec_t miss;
	mgr_vec_t miss_acc;
	mgr_vec_t pend_q;     // read accepted, R not yet taken
	mgr_vec_t miss_q;

	mgr_vec_t req [`XBAR_SUB_N];
	mgr_vec_t grant [`XBAR_SUB_N];
	mgr_idx_t gnt_idx [`XBAR_SUB_N];
	sub_vec_t busy;
	sub_vec_t take;
	sub_vec_t release_lock;

	rd_req_t [`XBAR_SUB_N-1:0] fwd_q;
	sub_vec_t fwd_v_q;
	rd_rsp_t [`XBAR_SUB_N-1:0] rrsp_q;
	sub_vec_t rv_q;

	for (genvar i = 0; i < `XBAR_MGR_N; i++) begin : g_mgr
		xbar_addr_decode u_dec (
			.addr   (rd_req[i].addr),
			.sub_sel(sel[i]),
			.miss   (miss[i])
		);
	end

	assign miss_acc = rd_valid & ~pend_q & miss;

	always_comb begin
		for (int s = 0; s < `XBAR_SUB_N; s++) begin
			for (int m = 0; m < `XBAR_MGR_N; m++) begin
				req[s][m] = rd_valid[m] && !pend_q[m] && !miss[m] && sel[m] == sub_idx_t'(s);
			end
		end
	end

	for (genvar s = 0; s < `XBAR_SUB_N; s++) begin : g_sub
		xbar_rr_arbiter u_arb (
			.clk         (clk),
			.arst_n      (arst_n),
			.req         (req[s]),
			.release_lock(release_lock[s]),
			.grant       (grant[s]),
			.gnt_idx     (gnt_idx[s]),
			.busy        (busy[s])
		);

		assign take[s] = |grant[s] && !busy[s];
		assign release_lock[s] = rv_q[s] && r_ready[gnt_idx[s]];
		assign s_r_ready[s] = busy[s] && !fwd_v_q[s] && !rv_q[s];
	end

	always_comb begin
		rd_ready = miss_acc;
		for (int s = 0; s < `XBAR_SUB_N; s++) begin
			if (take[s]) begin
				rd_ready = rd_ready | grant[s];
			end
		end
	end

	always_comb begin
		r_valid = miss_q;
		for (int m = 0; m < `XBAR_MGR_N; m++) begin
			rd_rsp[m] = '{data: '0, resp: RESP_DECERR};   // miss reply, data zero
		end
		for (int s = 0; s < `XBAR_SUB_N; s++) begin
			if (rv_q[s]) begin
				r_valid[gnt_idx[s]] = 1'b1;
				rd_rsp[gnt_idx[s]] = rrsp_q[s];
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pend_q <= '0;
			miss_q <= '0;
			fwd_v_q <= '0;
			rv_q <= '0;
		end else begin
			pend_q <= (pend_q | (rd_valid & rd_ready)) & ~(r_valid & r_ready);
			miss_q <= (miss_q & ~r_ready) | miss_acc;
			for (int s = 0; s < `XBAR_SUB_N; s++) begin
				if (take[s]) begin
					fwd_v_q[s] <= 1'b1;
				end else if (s_rd_ready[s]) begin
					fwd_v_q[s] <= 1'b0;
				end
				if (s_r_valid[s] && s_r_ready[s]) begin
					rv_q[s] <= 1'b1;
				end else if (release_lock[s]) begin
					rv_q[s] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int s = 0; s < `XBAR_SUB_N; s++) begin
			if (take[s]) begin
				fwd_q[s] <= rd_req[gnt_idx[s]];
			end
			if (s_r_valid[s] && s_r_ready[s]) begin
				rrsp_q[s] <= s_rd_rsp[s];
			end
		end
	end

	assign s_rd_req = fwd_q;
	assign s_rd_valid = fwd_v_q;

endmodule

//--- logic/xbar_rr_arbiter.sv
// round-robin arbiter for one subordinate lane
// a grant is given in the cycle the request shows up, then held
// until release_lock, new requests wait while busy
// after reset the search starts at manager 0 (dm)
`include "xbar_settings.svh"

module xbar_rr_arbiter
	import xbar_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input mgr_vec_t req,
	input logic release_lock,
	output mgr_vec_t grant,
	output mgr_idx_t gnt_idx,
	output logic busy
);

	mgr_idx_t last_q;   // last grantee, also the lock owner while busy
	logic busy_q;
	mgr_idx_t pick_idx;
	logic pick_any;

	// search starts one past the last grantee
	always_comb begin
		int cand;
		pick_any = 1'b0;
		pick_idx = last_q;
		for (int k = 1; k <= `XBAR_MGR_N; k++) begin
			cand = (int'(last_q) + k) % `XBAR_MGR_N;
			if (!pick_any && req[cand]) begin
				pick_any = 1'b1;
				pick_idx = mgr_idx_t'(cand);
			end
		end
	end

	assign busy = busy_q;
	assign gnt_idx = busy_q ? last_q : pick_idx;
	assign grant = (busy_q || pick_any) ? mgr_vec_t'(1) << gnt_idx : '0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy_q <= 1'b0;
			last_q <= mgr_idx_t'(`XBAR_MGR_N - 1);   // dm comes first
		end else if (busy_q) begin
			if (release_lock) begin
				busy_q <= 1'b0;
			end
		end else if (pick_any) begin
			busy_q <= 1'b1;
			last_q <= pick_idx;
		end
	end

	assert property (@(posedge clk) disable iff (!arst_n) $onehot0(grant));

	// the lock owner cannot change before release
	assert property (@(posedge clk) disable iff (!arst_n)
		busy && !release_lock |=> busy && $stable(grant));

endmodule

//--- logic/xbar_top.sv
// 3 x 5 AXI4-Lite crossbar, managers dm, ifu, lsu
// subordinates clint, plic, preph, sys, mem
// a write needs AW and W presented together on wr_valid
// prot is not carried
`include "xbar_settings.svh"

module xbar_top
	import xbar_pkg::*;
(
	input logic clk,
	input logic arst_n,
	// managers
	input wr_req_t dm_wr_req, ifu_wr_req, lsu_wr_req,
	input logic dm_wr_valid, ifu_wr_valid, lsu_wr_valid,
	output logic dm_wr_ready, ifu_wr_ready, lsu_wr_ready,
	output wr_rsp_t dm_wr_rsp, ifu_wr_rsp, lsu_wr_rsp,
	output logic dm_b_valid, ifu_b_valid, lsu_b_valid,
	input logic dm_b_ready, ifu_b_ready, lsu_b_ready,
	input rd_req_t dm_rd_req, ifu_rd_req, lsu_rd_req,
	input logic dm_rd_valid, ifu_rd_valid, lsu_rd_valid,
	output logic dm_rd_ready, ifu_rd_ready, lsu_rd_ready,
	output rd_rsp_t dm_rd_rsp, ifu_rd_rsp, lsu_rd_rsp,
	output logic dm_r_valid, ifu_r_valid, lsu_r_valid,
	input logic dm_r_ready, ifu_r_ready, lsu_r_ready,
	// subordinates
	output wr_req_t clint_wr_req, plic_wr_req, preph_wr_req, sys_wr_req, mem_wr_req,
	output logic clint_wr_valid, plic_wr_valid, preph_wr_valid, sys_wr_valid, mem_wr_valid,
	input logic clint_wr_ready, plic_wr_ready, preph_wr_ready, sys_wr_ready, mem_wr_ready,
	input wr_rsp_t clint_wr_rsp, plic_wr_rsp, preph_wr_rsp, sys_wr_rsp, mem_wr_rsp,
	input logic clint_b_valid, plic_b_valid, preph_b_valid, sys_b_valid, mem_b_valid,
	output logic clint_b_ready, plic_b_ready, preph_b_ready, sys_b_ready, mem_b_ready,
	output rd_req_t clint_rd_req, plic_rd_req, preph_rd_req, sys_rd_req, mem_rd_req,
	output logic clint_rd_valid, plic_rd_valid, preph_rd_valid, sys_rd_valid, mem_rd_valid,
	input logic clint_rd_ready, plic_rd_ready, preph_rd_ready, sys_rd_ready, mem_rd_ready,
	input rd_rsp_t clint_rd_rsp, plic_rd_rsp, preph_rd_rsp, sys_rd_rsp, mem_rd_rsp,
	input logic clint_r_valid, plic_r_valid, preph_r_valid, sys_r_valid, mem_r_valid,
	output logic clint_r_ready, plic_r_ready, preph_r_ready, sys_r_ready, mem_r_ready
);

	// array index 0 is dm / clint, highest index goes first in each concat
	xbar_write_path u_wr (
		.clk       (clk),
		.arst_n    (arst_n),
		.wr_req    ({lsu_wr_req, ifu_wr_req, dm_wr_req}),
		.wr_valid  ({lsu_wr_valid, ifu_wr_valid, dm_wr_valid}),
		.wr_ready  ({lsu_wr_ready, ifu_wr_ready, dm_wr_ready}),
		.wr_rsp    ({lsu_wr_rsp, ifu_wr_rsp, dm_wr_rsp}),
		.b_valid   ({lsu_b_valid, ifu_b_valid, dm_b_valid}),
		.b_ready   ({lsu_b_ready, ifu_b_ready, dm_b_ready}),
		.s_wr_req  ({mem_wr_req, sys_wr_req, preph_wr_req, plic_wr_req, clint_wr_req}),
		.s_wr_valid({mem_wr_valid, sys_wr_valid, preph_wr_valid, plic_wr_valid, clint_wr_valid}),
		.s_wr_ready({mem_wr_ready, sys_wr_ready, preph_wr_ready, plic_wr_ready, clint_wr_ready}),
		.s_wr_rsp  ({mem_wr_rsp, sys_wr_rsp, preph_wr_rsp, plic_wr_rsp, clint_wr_rsp}),
		.s_b_valid ({mem_b_valid, sys_b_valid, preph_b_valid, plic_b_valid, clint_b_valid}),
		.s_b_ready ({mem_b_ready, sys_b_ready, preph_b_ready, plic_b_ready, clint_b_ready})
	);

	xbar_read_path u_rd (
		.clk       (clk),
		.arst_n    (arst_n),
		.rd_req    ({lsu_rd_req, ifu_rd_req, dm_rd_req}),
		.rd_valid  ({lsu_rd_valid, ifu_rd_valid, dm_rd_valid}),
		.rd_ready  ({lsu_rd_ready, ifu_rd_ready, dm_rd_ready}),
		.rd_rsp    ({lsu_rd_rsp, ifu_rd_rsp, dm_rd_rsp}),
		.r_valid   ({lsu_r_valid, ifu_r_valid, dm_r_valid}),
		.r_ready   ({lsu_r_ready, ifu_r_ready, dm_r_ready}),
		.s_rd_req  ({mem_rd_req, sys_rd_req, preph_rd_req, plic_rd_req, clint_rd_req}),
		.s_rd_valid({mem_rd_valid, sys_rd_valid, preph_rd_valid, plic_rd_valid, clint_rd_valid}),
		.s_rd_ready({mem_rd_ready, sys_rd_ready, preph_rd_ready, plic_rd_ready, clint_rd_ready}),
		.s_rd_rsp  ({mem_rd_rsp, sys_rd_rsp, preph_rd_rsp, plic_rd_rsp, clint_rd_rsp}),
		.s_r_valid ({mem_r_valid, sys_r_valid, preph_r_valid, plic_r_valid, clint_r_valid}),
		.s_r_ready ({mem_r_ready, sys_r_ready, preph_r_ready, plic_r_ready, clint_r_ready})
	);

endmodule

//--- logic/xbar_write_path.sv
// write side of the crossbar, AW and W travel as one request
// one write in flight per manager, a lane stays locked to its
// manager until that manager takes the B response
// unmapped writes are accepted at once and answered with DECERR
`include "xbar_settings.svh"

module xbar_write_path
	import xbar_pkg::*;
(
	input logic clk,
	input logic arst_n,
	// manager side
	input wr_req_t [`XBAR_MGR_N-1:0] wr_req,
	input mgr_vec_t wr_valid,
	output mgr_vec_t wr_ready,
	output wr_rsp_t [`XBAR_MGR_N-1:0] wr_rsp,
	output mgr_vec_t b_valid,
	input mgr_vec_t b_ready,
	// subordinate side
	output wr_req_t [`XBAR_SUB_N-1:0] s_wr_req,
	output sub_vec_t s_wr_valid,
	input sub_vec_t s_wr_ready,
	input wr_rsp_t [`XBAR_SUB_N-1:0] s_wr_rsp,
	input sub_vec_t s_b_valid,
	output sub_vec_t s_b_ready
);

	sub_idx_t sel [`XBAR_MGR_N];
	mgr_vec_t miss;
	mgr_vec_t miss_acc;   // unmapped write taken this cycle
	mgr_vec_t pend_q;     // write accepted, B not yet taken
	mgr_vec_t miss_q;     // DECERR owed

	mgr_vec_t req [`XBAR_SUB_N];
	mgr_vec_t grant [`XBAR_SUB_N];
	mgr_idx_t gnt_idx [`XBAR_SUB_N];
	sub_vec_t busy;
	sub_vec_t take;       // fresh grant, not the held one
	sub_vec_t release_lock;

	wr_req_t [`XBAR_SUB_N-1:0] fwd_q;
	sub_vec_t fwd_v_q;
	wr_rsp_t [`XBAR_SUB_N-1:0] brsp_q;
	sub_vec_t bv_q;

	for (genvar i = 0; i < `XBAR_MGR_N; i++) begin : g_mgr
		xbar_addr_decode u_dec (
			.addr   (wr_req[i].addr),
			.sub_sel(sel[i]),
			.miss   (miss[i])
		);

		// B only ever answers a write this path took
		assert property (@(posedge clk) disable iff (!arst_n) b_valid[i] |-> pend_q[i]);
	end

	assign miss_acc = wr_valid & ~pend_q & miss;

	always_comb begin
		for (int s = 0; s < `XBAR_SUB_N; s++) begin
			for (int m = 0; m < `XBAR_MGR_N; m++) begin
				req[s][m] = wr_valid[m] && !pend_q[m] && !miss[m] && sel[m] == sub_idx_t'(s);
			end
		end
	end

	for (genvar s = 0; s < `XBAR_SUB_N; s++) begin : g_sub
		xbar_rr_arbiter u_arb (
			.clk         (clk),
			.arst_n      (arst_n),
			.req         (req[s]),
			.release_lock(release_lock[s]),
			.grant       (grant[s]),
			.gnt_idx     (gnt_idx[s]),
			.busy        (busy[s])
		);

		assign take[s] = |grant[s] && !busy[s];
		assign release_lock[s] = bv_q[s] && b_ready[gnt_idx[s]];
		// B taken only once the request has left the register
		assign s_b_ready[s] = busy[s] && !fwd_v_q[s] && !bv_q[s];
	end

	always_comb begin
		wr_ready = miss_acc;
		for (int s = 0; s < `XBAR_SUB_N; s++) begin
			if (take[s]) begin
				wr_ready = wr_ready | grant[s];
			end
		end
	end

	// response mux, a lane answers only its lock owner
	always_comb begin
		b_valid = miss_q;
		for (int m = 0; m < `XBAR_MGR_N; m++) begin
			wr_rsp[m].resp = RESP_DECERR;
		end
		for (int s = 0; s < `XBAR_SUB_N; s++) begin
			if (bv_q[s]) begin
				b_valid[gnt_idx[s]] = 1'b1;
				wr_rsp[gnt_idx[s]] = brsp_q[s];
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pend_q <= '0;
			miss_q <= '0;
			fwd_v_q <= '0;
			bv_q <= '0;
		end else begin
			pend_q <= (pend_q | (wr_valid & wr_ready)) & ~(b_valid & b_ready);
			miss_q <= (miss_q & ~b_ready) | miss_acc;
			for (int s = 0; s < `XBAR_SUB_N; s++) begin
				if (take[s]) begin
					fwd_v_q[s] <= 1'b1;
				end else if (s_wr_ready[s]) begin
					fwd_v_q[s] <= 1'b0;
				end
				if (s_b_valid[s] && s_b_ready[s]) begin
					bv_q[s] <= 1'b1;
				end else if (release_lock[s]) begin
					bv_q[s] <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int s = 0; s < `XBAR_SUB_N; s++) begin
			if (take[s]) begin
				fwd_q[s] <= wr_req[gnt_idx[s]];
			end
			if (s_b_valid[s] && s_b_ready[s]) begin
				brsp_q[s] <= s_wr_rsp[s];
			end
		end
	end

	assign s_wr_req = fwd_q;
	assign s_wr_valid = fwd_v_q;

endmodule

//--- verif/tb_top.sv
// testbench for the 3 x 5 crossbar
// managers and subordinate models drive 2 ns after the rising edge
// subordinate models hold 16 words, indexed by address bits 6 to 3
// the random stream is seeded with 83
`include "xbar_settings.svh"

module tb_top
	import xbar_pkg::*;
;

	timeunit 1ns;
	timeprecision 1ns;

	localparam int N_TXN = 174;   // routing 30, miss 6, raw 6, rr 12, random 120

	logic clk = 1'b0;
	logic arst_n = 1'b0;
	int seed = 83;
	logic stall = 1'b0;
	int err_base = 0;

	wr_req_t m_wr_req [`XBAR_MGR_N];
	mgr_vec_t m_wr_valid;
	wire mgr_vec_t m_wr_ready;
	wire wr_rsp_t m_wr_rsp [`XBAR_MGR_N];
	wire mgr_vec_t m_b_valid;
	mgr_vec_t m_b_ready;
	rd_req_t m_rd_req [`XBAR_MGR_N];
	mgr_vec_t m_rd_valid;
	wire mgr_vec_t m_rd_ready;
	wire rd_rsp_t m_rd_rsp [`XBAR_MGR_N];
	wire mgr_vec_t m_r_valid;
	mgr_vec_t m_r_ready;

	wire wr_req_t s_wr_req [`XBAR_SUB_N];
	wire sub_vec_t s_wr_valid;
	sub_vec_t s_wr_ready;
	wr_rsp_t s_wr_rsp [`XBAR_SUB_N];
	sub_vec_t s_b_valid;
	wire sub_vec_t s_b_ready;
	wire rd_req_t s_rd_req [`XBAR_SUB_N];
	wire sub_vec_t s_rd_valid;
	sub_vec_t s_rd_ready;
	rd_rsp_t s_rd_rsp [`XBAR_SUB_N];
	sub_vec_t s_r_valid;
	wire sub_vec_t s_r_ready;

	data_t mem [`XBAR_SUB_N][16];
	addr_t region_base [`XBAR_SUB_N + 1] = '{`XBAR_CLINT_BASE, `XBAR_PLIC_BASE,
		`XBAR_PREPH_BASE, `XBAR_SYS_BASE, `XBAR_MEM_BASE, 64'h0000_0000_1000_0000};

	always #20 clk = ~clk;

	xbar_top dut (
		.clk(clk),
		.arst_n(arst_n),
		.dm_wr_req(m_wr_req[0]), .ifu_wr_req(m_wr_req[1]), .lsu_wr_req(m_wr_req[2]),
		.dm_wr_valid(m_wr_valid[0]), .ifu_wr_valid(m_wr_valid[1]), .lsu_wr_valid(m_wr_valid[2]),
		.dm_wr_ready(m_wr_ready[0]), .ifu_wr_ready(m_wr_ready[1]), .lsu_wr_ready(m_wr_ready[2]),
		.dm_wr_rsp(m_wr_rsp[0]), .ifu_wr_rsp(m_wr_rsp[1]), .lsu_wr_rsp(m_wr_rsp[2]),
		.dm_b_valid(m_b_valid[0]), .ifu_b_valid(m_b_valid[1]), .lsu_b_valid(m_b_valid[2]),
		.dm_b_ready(m_b_ready[0]), .ifu_b_ready(m_b_ready[1]), .lsu_b_ready(m_b_ready[2]),
		.dm_rd_req(m_rd_req[0]), .ifu_rd_req(m_rd_req[1]), .lsu_rd_req(m_rd_req[2]),
		.dm_rd_valid(m_rd_valid[0]), .ifu_rd_valid(m_rd_valid[1]), .lsu_rd_valid(m_rd_valid[2]),
		.dm_rd_ready(m_rd_ready[0]), .ifu_rd_ready(m_rd_ready[1]), .lsu_rd_ready(m_rd_ready[2]),
		.dm_rd_rsp(m_rd_rsp[0]), .ifu_rd_rsp(m_rd_rsp[1]), .lsu_rd_rsp(m_rd_rsp[2]),
		.dm_r_valid(m_r_valid[0]), .ifu_r_valid(m_r_valid[1]), .lsu_r_valid(m_r_valid[2]),
		.dm_r_ready(m_r_ready[0]), .ifu_r_ready(m_r_ready[1]), .lsu_r_ready(m_r_ready[2]),
		.clint_wr_req(s_wr_req[0]), .plic_wr_req(s_wr_req[1]), .preph_wr_req(s_wr_req[2]),
		.sys_wr_req(s_wr_req[3]), .mem_wr_req(s_wr_req[4]),
		.clint_wr_valid(s_wr_valid[0]), .plic_wr_valid(s_wr_valid[1]),
		.preph_wr_valid(s_wr_valid[2]), .sys_wr_valid(s_wr_valid[3]),
		.mem_wr_valid(s_wr_valid[4]),
		.clint_wr_ready(s_wr_ready[0]), .plic_wr_ready(s_wr_ready[1]),
		.preph_wr_ready(s_wr_ready[2]), .sys_wr_ready(s_wr_ready[3]),
		.mem_wr_ready(s_wr_ready[4]),
		.clint_wr_rsp(s_wr_rsp[0]), .plic_wr_rsp(s_wr_rsp[1]), .preph_wr_rsp(s_wr_rsp[2]),
		.sys_wr_rsp(s_wr_rsp[3]), .mem_wr_rsp(s_wr_rsp[4]),
		.clint_b_valid(s_b_valid[0]), .plic_b_valid(s_b_valid[1]), .preph_b_valid(s_b_valid[2]),
		.sys_b_valid(s_b_valid[3]), .mem_b_valid(s_b_valid[4]),
		.clint_b_ready(s_b_ready[0]), .plic_b_ready(s_b_ready[1]), .preph_b_ready(s_b_ready[2]),
		.sys_b_ready(s_b_ready[3]), .mem_b_ready(s_b_ready[4]),
		.clint_rd_req(s_rd_req[0]), .plic_rd_req(s_rd_req[1]), .preph_rd_req(s_rd_req[2]),
		.sys_rd_req(s_rd_req[3]), .mem_rd_req(s_rd_req[4]),
		.clint_rd_valid(s_rd_valid[0]), .plic_rd_valid(s_rd_valid[1]),
		.preph_rd_valid(s_rd_valid[2]), .sys_rd_valid(s_rd_valid[3]),
		.mem_rd_valid(s_rd_valid[4]),
		.clint_rd_ready(s_rd_ready[0]), .plic_rd_ready(s_rd_ready[1]),
		.preph_rd_ready(s_rd_ready[2]), .sys_rd_ready(s_rd_ready[3]),
		.mem_rd_ready(s_rd_ready[4]),
		.clint_rd_rsp(s_rd_rsp[0]), .plic_rd_rsp(s_rd_rsp[1]), .preph_rd_rsp(s_rd_rsp[2]),
		.sys_rd_rsp(s_rd_rsp[3]), .mem_rd_rsp(s_rd_rsp[4]),
		.clint_r_valid(s_r_valid[0]), .plic_r_valid(s_r_valid[1]), .preph_r_valid(s_r_valid[2]),
		.sys_r_valid(s_r_valid[3]), .mem_r_valid(s_r_valid[4]),
		.clint_r_ready(s_r_ready[0]), .plic_r_ready(s_r_ready[1]), .preph_r_ready(s_r_ready[2]),
		.sys_r_ready(s_r_ready[3]), .mem_r_ready(s_r_ready[4])
	);

	xbar_checker chk (.*);

	// subordinate models, OKAY after a random delay
	for (genvar s = 0; s < `XBAR_SUB_N; s++) begin : g_sub
		int b_wait = -1;
		int r_wait = -1;
		logic wr_hs = 1'b0;
		logic rd_hs = 1'b0;
		logic b_hs = 1'b0;
		logic r_hs = 1'b0;
		wr_req_t wr_seen;
		rd_req_t rd_seen;

		always @(negedge clk) begin
			wr_hs = s_wr_valid[s] && s_wr_ready[s];
			rd_hs = s_rd_valid[s] && s_rd_ready[s];
			b_hs = s_b_valid[s] && s_b_ready[s];
			r_hs = s_r_valid[s] && s_r_ready[s];
			wr_seen = s_wr_req[s];
			rd_seen = s_rd_req[s];
		end

		always @(posedge clk) begin
			#2;
			if (rd_hs) begin   // read before write, as in the checker
				s_rd_rsp[s] = '{data: mem[s][rd_seen.addr[6:3]], resp: RESP_OKAY};
				r_wait = {$random(seed)} % 4;
			end
			if (wr_hs) begin
				for (int b = 0; b < `XBAR_DATA_W / 8; b++) begin
					if (wr_seen.strb[b]) mem[s][wr_seen.addr[6:3]][8*b +: 8] = wr_seen.data[8*b +: 8];
				end
				s_wr_rsp[s].resp = RESP_OKAY;
				b_wait = {$random(seed)} % 4;
			end
			if (b_hs) s_b_valid[s] = 1'b0;
			if (r_hs) s_r_valid[s] = 1'b0;
			if (b_wait == 0) s_b_valid[s] = 1'b1;
			if (b_wait >= 0) b_wait--;
			if (r_wait == 0) s_r_valid[s] = 1'b1;
			if (r_wait >= 0) r_wait--;
			s_wr_ready[s] = ({$random(seed)} % 4) != 0;
			s_rd_ready[s] = ({$random(seed)} % 4) != 0;
		end
	end

	// response stalls on the manager side
	always @(posedge clk) begin
		#2;
		for (int m = 0; m < `XBAR_MGR_N; m++) begin
			m_b_ready[m] = stall ? ({$random(seed)} % 3) != 0 : 1'b1;
			m_r_ready[m] = stall ? ({$random(seed)} % 3) != 0 : 1'b1;
		end
	end

	function automatic addr_t random_addr(int r);
		random_addr = region_base[r] + addr_t'({$random(seed)} & 32'h0000_ff78);
	endfunction

	// called and returning 2 ns after a rising edge
	task automatic write_txn(int m, addr_t a, data_t d, strb_t st);
		m_wr_req[m] = '{addr: a, data: d, strb: st};
		m_wr_valid[m] = 1'b1;
		do @(negedge clk); while (!m_wr_ready[m]);
		@(posedge clk);
		#2;
		m_wr_valid[m] = 1'b0;
		do @(negedge clk); while (!(m_b_valid[m] && m_b_ready[m]));
		@(posedge clk);
		#2;
	endtask

	task automatic read_txn(int m, addr_t a);
		m_rd_req[m] = '{addr: a};
		m_rd_valid[m] = 1'b1;
		do @(negedge clk); while (!m_rd_ready[m]);
		@(posedge clk);
		#2;
		m_rd_valid[m] = 1'b0;
		do @(negedge clk); while (!(m_r_valid[m] && m_r_ready[m]));
		@(posedge clk);
		#2;
	endtask

	task automatic random_traffic(int m);
		int r;
		for (int n = 0; n < 40; n++) begin
			r = {$random(seed)} % 6;   // 5 picks an unmapped address
			if ($random(seed) & 1) begin
				write_txn(m, random_addr(r), {$random(seed), $random(seed)}, strb_t'($random(seed)));
			end else begin
				read_txn(m, random_addr(r));
			end
		end
	endtask

	task automatic start_test(string name);
		chk.test_name = name;
		err_base = chk.errors;
	endtask

	task automatic finish_test();
		$display("test %s done, %0d errors", chk.test_name, chk.errors - err_base);
	endtask

	initial begin
		repeat (N_TXN * 200) @(posedge clk);
		$display("watchdog expired, transactions did not complete");
		$display("Some tests failed");
		$finish;
	end

	initial begin
		addr_t a;
		for (int m = 0; m < `XBAR_MGR_N; m++) begin
			m_wr_req[m] = '0;
			m_rd_req[m] = '0;
		end
		m_wr_valid = '0;
		m_rd_valid = '0;
		m_b_ready = '1;
		m_r_ready = '1;
		s_wr_ready = '0;
		s_rd_ready = '0;
		s_b_valid = '0;
		s_r_valid = '0;
		for (int s = 0; s < `XBAR_SUB_N; s++) begin
			s_wr_rsp[s] = '0;
			s_rd_rsp[s] = '0;
			for (int i = 0; i < 16; i++) begin
				mem[s][i] = data_t'(s * 256 + i);
			end
		end
		repeat (4) @(posedge clk);
		#2;
		arst_n = 1'b1;

		start_test("routing");
		for (int m = 0; m < `XBAR_MGR_N; m++) begin
			for (int s = 0; s < `XBAR_SUB_N; s++) begin
				a = random_addr(s);
				write_txn(m, a, {$random(seed), $random(seed)}, '1);
				read_txn(m, a);
			end
		end
		finish_test();

		start_test("miss");
		for (int m = 0; m < `XBAR_MGR_N; m++) begin
			write_txn(m, random_addr(5), {$random(seed), $random(seed)}, '1);
			read_txn(m, 64'h0000_0001_8000_0000);   // upper bits set
		end
		finish_test();

		start_test("raw");
		for (int m = 0; m < `XBAR_MGR_N; m++) begin
			a = random_addr(4);
			write_txn(m, a, {$random(seed), $random(seed)}, strb_t'($random(seed)));
			read_txn((m + 1) % `XBAR_MGR_N, a);
		end
		finish_test();

		// each manager asks again right away, so the last owner competes too
		start_test("rr");
		fork
			repeat (4) read_txn(0, random_addr(4));
			repeat (4) read_txn(1, random_addr(4));
			repeat (4) read_txn(2, random_addr(4));
		join
		finish_test();

		start_test("random");
		stall = 1'b1;
		fork
			random_traffic(0);
			random_traffic(1);
			random_traffic(2);
		join
		stall = 1'b0;
		finish_test();

		$display("%0d checks, %0d errors", chk.checks, chk.errors);
		if (chk.errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- verif/xbar_checker.sv
// watches both sides of the crossbar and compares against a reference model
// samples on the falling edge, a valid and ready pair seen there
// is a transfer on the following rising edge
// shadow memory mirrors the subordinate models, 16 words each
`include "xbar_settings.svh"

module xbar_checker
	import xbar_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input wr_req_t m_wr_req [`XBAR_MGR_N],
	input mgr_vec_t m_wr_valid,
	input mgr_vec_t m_wr_ready,
	input wr_rsp_t m_wr_rsp [`XBAR_MGR_N],
	input mgr_vec_t m_b_valid,
	input mgr_vec_t m_b_ready,
	input rd_req_t m_rd_req [`XBAR_MGR_N],
	input mgr_vec_t m_rd_valid,
	input mgr_vec_t m_rd_ready,
	input rd_rsp_t m_rd_rsp [`XBAR_MGR_N],
	input mgr_vec_t m_r_valid,
	input mgr_vec_t m_r_ready,
	input wr_req_t s_wr_req [`XBAR_SUB_N],
	input sub_vec_t s_wr_valid,
	input sub_vec_t s_wr_ready,
	input sub_vec_t s_b_valid,
	input sub_vec_t s_b_ready,
	input rd_req_t s_rd_req [`XBAR_SUB_N],
	input sub_vec_t s_rd_valid,
	input sub_vec_t s_rd_ready,
	input sub_vec_t s_r_valid,
	input sub_vec_t s_r_ready
);

	timeunit 1ns;
	timeprecision 1ns;

	string test_name = "none";
	int errors = 0;
	int checks = 0;

	data_t shadow [`XBAR_SUB_N][16];
	int w_sub [`XBAR_MGR_N];   // -1 on a decode miss
	int r_sub [`XBAR_MGR_N];
	wr_req_t w_req [`XBAR_MGR_N];
	rd_req_t r_req [`XBAR_MGR_N];
	data_t r_exp [`XBAR_MGR_N];
	mgr_vec_t w_pend = '0;
	mgr_vec_t r_pend = '0;
	mgr_vec_t w_fwd = '0;   // request seen on the subordinate side
	mgr_vec_t r_fwd = '0;
	mgr_vec_t w_done = '0;  // subordinate B taken by the crossbar
	mgr_vec_t r_done = '0;
	int last_w [`XBAR_SUB_N];
	int last_r [`XBAR_SUB_N];

	// reference routing from the address map
	function automatic int expected_sub(addr_t a);
		addr_t base [`XBAR_SUB_N] = '{`XBAR_CLINT_BASE, `XBAR_PLIC_BASE,
			`XBAR_PREPH_BASE, `XBAR_SYS_BASE, `XBAR_MEM_BASE};
		addr_t mask [`XBAR_SUB_N] = '{`XBAR_CLINT_MASK, `XBAR_PLIC_MASK,
			`XBAR_PREPH_MASK, `XBAR_SYS_MASK, `XBAR_MEM_MASK};
		expected_sub = -1;
		for (int s = 0; s < `XBAR_SUB_N; s++) begin
			if (a >= base[s] && a <= base[s] + mask[s]) begin   // base up to base plus size
				expected_sub = s;
			end
		end
	endfunction

	function automatic data_t expected_data(int s, addr_t a);
		expected_data = (s < 0) ? '0 : shadow[s][a[6:3]];   // miss reads back zero
	endfunction

	function automatic data_t merge_bytes(data_t old, data_t d, strb_t st);
		merge_bytes = old;
		for (int b = 0; b < `XBAR_DATA_W / 8; b++) begin
			if (st[b]) begin
				merge_bytes[8*b +: 8] = d[8*b +: 8];
			end
		end
	endfunction

	// rotation rule, first requester after the last grantee
	function automatic int next_owner(mgr_vec_t reqs, int last);
		next_owner = -1;
		for (int k = `XBAR_MGR_N; k >= 1; k--) begin
			if (reqs[(last + k) % `XBAR_MGR_N]) begin
				next_owner = (last + k) % `XBAR_MGR_N;
			end
		end
	endfunction

	task automatic compare_value(string what, logic [63:0] exp, logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAILED %s %s expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic report_text(string msg);
		errors++;
		$display("error in %s: %s", test_name, msg);
	endtask

	initial begin
		for (int s = 0; s < `XBAR_SUB_N; s++) begin
			last_w[s] = `XBAR_MGR_N - 1;   // dm comes first after reset
			last_r[s] = `XBAR_MGR_N - 1;
			for (int i = 0; i < 16; i++) begin
				shadow[s][i] = data_t'(s * 256 + i);
			end
		end
	end

	always @(negedge clk) begin
		mgr_vec_t reqs;
		mgr_vec_t w_now;
		mgr_vec_t r_now;
		int s;
		int owner;
		if (arst_n) begin
			w_now = w_pend;
			r_now = r_pend;
			// new requests on the manager side
			for (int m = 0; m < `XBAR_MGR_N; m++) begin
				if (m_rd_valid[m] && m_rd_ready[m]) begin
					s = expected_sub(m_rd_req[m].addr);
					if (r_now[m]) report_text("read accepted while one is outstanding");
					if (s >= 0) begin
						for (int k = 0; k < `XBAR_MGR_N; k++) begin
							reqs[k] = m_rd_valid[k] && !r_now[k] &&
								expected_sub(m_rd_req[k].addr) == s;
						end
						compare_value("read grant", 64'(next_owner(reqs, last_r[s])), 64'(m));
						last_r[s] = m;
					end
					r_sub[m] = s;
					r_req[m] = m_rd_req[m];
					r_pend[m] = 1'b1;
				end
				if (m_wr_valid[m] && m_wr_ready[m]) begin
					s = expected_sub(m_wr_req[m].addr);
					if (w_now[m]) report_text("write accepted while one is outstanding");
					if (s >= 0) begin
						for (int k = 0; k < `XBAR_MGR_N; k++) begin
							reqs[k] = m_wr_valid[k] && !w_now[k] &&
								expected_sub(m_wr_req[k].addr) == s;
						end
						compare_value("write grant", 64'(next_owner(reqs, last_w[s])), 64'(m));
						last_w[s] = m;
					end
					w_sub[m] = s;
					w_req[m] = m_wr_req[m];
					w_pend[m] = 1'b1;
				end
			end
			// subordinate side, reads before writes like the models
			for (int t = 0; t < `XBAR_SUB_N; t++) begin
				if (s_rd_valid[t] && s_rd_ready[t]) begin
					owner = -1;
					for (int k = 0; k < `XBAR_MGR_N; k++) begin
						if (r_now[k] && !r_fwd[k] && r_sub[k] == t) owner = k;
					end
					if (owner < 0) begin
						report_text($sformatf("read reached subordinate %0d unasked", t));
					end else begin
						compare_value("read address", r_req[owner].addr, s_rd_req[t].addr);
						r_exp[owner] = expected_data(t, r_req[owner].addr);
						r_fwd[owner] = 1'b1;
					end
				end
			end
			for (int t = 0; t < `XBAR_SUB_N; t++) begin
				if (s_wr_valid[t] && s_wr_ready[t]) begin
					owner = -1;
					for (int k = 0; k < `XBAR_MGR_N; k++) begin
						if (w_now[k] && !w_fwd[k] && w_sub[k] == t) owner = k;
					end
					if (owner < 0) begin
						report_text($sformatf("write reached subordinate %0d unasked", t));
					end else begin
						compare_value("write address", w_req[owner].addr, s_wr_req[t].addr);
						compare_value("write data", w_req[owner].data, s_wr_req[t].data);
						compare_value("write strobe", 64'(w_req[owner].strb),
							64'(s_wr_req[t].strb));
						shadow[t][w_req[owner].addr[6:3]] = merge_bytes(
							shadow[t][w_req[owner].addr[6:3]], w_req[owner].data,
							w_req[owner].strb);
						w_fwd[owner] = 1'b1;
					end
				end
			end
			// responses taken from the subordinates
			for (int t = 0; t < `XBAR_SUB_N; t++) begin
				if (s_r_valid[t] && s_r_ready[t]) begin
					owner = -1;
					for (int k = 0; k < `XBAR_MGR_N; k++) begin
						if (r_now[k] && r_fwd[k] && !r_done[k] && r_sub[k] == t) owner = k;
					end
					if (owner < 0) begin
						report_text($sformatf("R taken from subordinate %0d with no read open", t));
					end else begin
						r_done[owner] = 1'b1;
					end
				end
				if (s_b_valid[t] && s_b_ready[t]) begin
					owner = -1;
					for (int k = 0; k < `XBAR_MGR_N; k++) begin
						if (w_now[k] && w_fwd[k] && !w_done[k] && w_sub[k] == t) owner = k;
					end
					if (owner < 0) begin
						report_text($sformatf("B taken from subordinate %0d with no write open", t));
					end else begin
						w_done[owner] = 1'b1;
					end
				end
			end
			// responses back at the managers
			for (int m = 0; m < `XBAR_MGR_N; m++) begin
				if (m_r_valid[m] && m_r_ready[m]) begin
					if (!r_now[m]) begin
						report_text($sformatf("manager %0d got R without a read", m));
					end else if (r_sub[m] < 0) begin
						compare_value("read resp", 64'(RESP_DECERR), 64'(m_rd_rsp[m].resp));
						compare_value("read data", 64'(0), m_rd_rsp[m].data);
					end else begin
						if (!r_done[m]) report_text("R returned before the subordinate answered");
						compare_value("read resp", 64'(RESP_OKAY), 64'(m_rd_rsp[m].resp));
						compare_value("read data", r_exp[m], m_rd_rsp[m].data);
					end
					r_pend[m] = 1'b0;
					r_fwd[m] = 1'b0;
					r_done[m] = 1'b0;
				end
				if (m_b_valid[m] && m_b_ready[m]) begin
					if (!w_now[m]) begin
						report_text($sformatf("manager %0d got B without a write", m));
					end else if (w_sub[m] < 0) begin
						compare_value("write resp", 64'(RESP_DECERR), 64'(m_wr_rsp[m].resp));
					end else begin
						if (!w_done[m]) report_text("B returned before the subordinate answered");
						compare_value("write resp", 64'(RESP_OKAY), 64'(m_wr_rsp[m].resp));
					end
					w_pend[m] = 1'b0;
					w_fwd[m] = 1'b0;
					w_done[m] = 1'b0;
				end
			end
		end
	end

endmodule
